//--- icache.f
+incdir+.
icache_pkg.sv
icache_ctrl.sv
refill_counter.sv
line_buffer.sv
way_store.sv
icache_top.sv
tb_icache.sv

//--- icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req,
  input  logic                     hit,
  input  logic                     done,
  input  icache_pkg::way_t         victim,
  input  icache_pkg::addr_fields_t req_fields,
  output logic                     accept,
  output logic                     lookup,
  output logic                     refill_start,
  output logic                     sen,
  output logic                     ok,
  output icache_pkg::fill_t        fill
);

  icache_pkg::state_t state;
  icache_pkg::state_t state_next;
  icache_pkg::way_t   victim_q;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= icache_pkg::st_idle;
    else
      state <= state_next;
  end

  // Victim is taken at the miss and kept through the burst
  always_ff @(posedge clk)
  begin
    if (refill_start)
      victim_q <= victim;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      icache_pkg::st_idle:
        if (req)
          state_next = icache_pkg::st_lookup;
      icache_pkg::st_lookup:
        if (hit)
          state_next = icache_pkg::st_idle;
        else
          state_next = icache_pkg::st_refill;
      icache_pkg::st_refill:
        if (done)
          state_next = icache_pkg::st_fill;
      icache_pkg::st_fill:
        state_next = icache_pkg::st_lookup;
      default:
        state_next = icache_pkg::st_idle;
    endcase
  end

  assign accept       = (state == icache_pkg::st_idle) && req;
  assign lookup       = (state == icache_pkg::st_lookup);
  assign ok           = lookup && hit;
  assign refill_start = lookup && !hit;

  // Burst request drops once the last word is in
  assign sen = (state == icache_pkg::st_refill) && !done;

  assign fill.way   = victim_q;
  assign fill.index = req_fields.index;
  assign fill.tag   = req_fields.tag;
  assign fill.we    = (state == icache_pkg::st_fill);

  ////////////////////
  // Checks

  assert property (@(posedge clk) disable iff (rst)
    ok |-> !sen && !$past(sen));

  // Line write only after a completed burst
  assert property (@(posedge clk) disable iff (rst)
    fill.we |-> state == icache_pkg::st_fill && $past(done));

endmodule

//--- icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

  typedef enum logic [1:0] {
    st_idle,
    st_lookup,
    st_refill,
    st_fill
  } state_t;

  // Word address split, byte bits dropped
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0]   tag;
    logic [`ICACHE_INDEX_W-1:0] index;
    logic [`ICACHE_OFFS_W-1:0]  offset;
  } addr_fields_t;

  // Word 0 sits in the low 32 bits
  typedef logic [`ICACHE_LINE_WORDS-1:0][31:0] line_t;

  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;

  // Line write into one way of one set
  typedef struct packed {
    way_t                       way;
    logic [`ICACHE_INDEX_W-1:0] index;
    logic [`ICACHE_TAG_W-1:0]   tag;
    logic                       we;
  } fill_t;

endpackage

//--- icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

////////////////////
// Address fields above the two byte bits
`define ICACHE_TAG_W      22
`define ICACHE_INDEX_W    4
`define ICACHE_OFFS_W     4

////////////////////
// Cache geometry
`define ICACHE_WAYS       4
`define ICACHE_LINE_WORDS 16

// Age counter per way and set
`define ICACHE_AGE_W      2

`endif

//--- icache_top.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_top (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] insaddr,
  input  logic        req,
  output logic [31:0] ins,
  output logic        ok,
  output logic        sen,
  output logic [31:0] addr,
  input  logic        data_ok,
  input  logic [31:0] sdata
);

  icache_pkg::addr_fields_t  cur_fields;
  icache_pkg::addr_fields_t  req_fields;
  logic                      accept;
  logic                      lookup;
  logic                      refill_start;
  logic                      hit;
  logic                      done;
  icache_pkg::way_t          victim;
  icache_pkg::fill_t         fill;
  logic [`ICACHE_OFFS_W-1:0] word_offs;
  icache_pkg::line_t         line;

  assign cur_fields = insaddr[31:2];

  // Request held for the whole lookup and refill
  always_ff @(posedge clk)
  begin
    if (accept)
      req_fields <= cur_fields;
  end

  assign addr = {req_fields, 2'b00};

  ////////////////////
  // Blocks

  icache_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .hit          (hit),
    .done         (done),
    .victim       (victim),
    .req_fields   (req_fields),
    .accept       (accept),
    .lookup       (lookup),
    .refill_start (refill_start),
    .sen          (sen),
    .ok           (ok),
    .fill         (fill)
  );

  refill_counter u_counter (
    .clk          (clk),
    .rst          (rst),
    .start_offs   (req_fields.offset),
    .refill_start (refill_start),
    .sen          (sen),
    .data_ok      (data_ok),
    .word_offs    (word_offs),
    .done         (done)
  );

  line_buffer u_line_buffer (
    .clk       (clk),
    .rst       (rst),
    .data_ok   (data_ok),
    .word_offs (word_offs),
    .sdata     (sdata),
    .line      (line)
  );

  way_store u_way_store (
    .clk        (clk),
    .rst        (rst),
    .req_fields (req_fields),
    .lookup     (lookup),
    .fill       (fill),
    .line       (line),
    .hit        (hit),
    .victim     (victim),
    .ins        (ins)
  );

endmodule

//--- line_buffer.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module line_buffer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      data_ok,
  input  logic [`ICACHE_OFFS_W-1:0] word_offs,
  input  logic [31:0]               sdata,
  output icache_pkg::line_t         line
);

  ////////////////////
  // Refill words land at their wrapped slot

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      line <= '0;
    else if (data_ok)
      line[word_offs] <= sdata;
  end

endmodule

//--- refill_counter.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module refill_counter (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`ICACHE_OFFS_W-1:0] start_offs,
  input  logic                      refill_start,
  input  logic                      sen,
  input  logic                      data_ok,
  output logic [`ICACHE_OFFS_W-1:0] word_offs,
  output logic                      done
);

  // One extra bit so the count can reach a full line
  logic [`ICACHE_OFFS_W:0] count;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      count <= '0;
    else if (refill_start)
      count <= '0;
    else if (sen && data_ok)
      count <= count + 1'b1;
  end

  assign done = (count == `ICACHE_LINE_WORDS);

  // Wraps inside the line
  assign word_offs = start_offs + count[`ICACHE_OFFS_W-1:0];

  // Memory sends no word past the end of the line
  assert property (@(posedge clk) disable iff (rst)
    done |-> !data_ok);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_icache -f icache.f -o sim_icache

./obj_dir/sim_icache | tee sim.log

if grep -qx "Test passed" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

//--- tb_icache.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module tb_icache;

  localparam int n_entries  = 18;
  localparam int sets       = 1 << `ICACHE_INDEX_W;
  localparam int ok_timeout = 300;

  typedef struct packed {
    logic [31:0] addr;
    logic        miss;
  } entry_t;

  // Set 1 cold line, five tags in set 3, an offset 15 miss in set 15
  localparam logic [31:0] stim_addr [n_entries] = '{
    32'h0000_1048, 32'h0000_1054, 32'h0000_107c,
    32'h0004_00c0, 32'h0004_04c4, 32'h0004_08c8, 32'h0004_0ccc,
    32'h0004_00f0, 32'h0004_10d0, 32'h0004_04c4, 32'h0004_08c8,
    32'h0004_0cc0, 32'h0004_00c0,
    32'h0000_2ffc, 32'h0000_2fc0, 32'h0000_2fe0, 32'h0000_2ff8,
    32'h0000_1048
  };

  logic        clk;
  logic        rst;
  logic [31:0] insaddr;
  logic        req;
  logic [31:0] ins;
  logic        ok;
  logic        sen;
  logic [31:0] addr;
  logic        data_ok;
  logic [31:0] sdata;

  entry_t stim_table [n_entries];
  int     err_count;
  int     check_count;
  logic   timed_out;

  // Reference model state
  logic [`ICACHE_TAG_W-1:0] ref_tag   [`ICACHE_WAYS][sets];
  logic                     ref_valid [`ICACHE_WAYS][sets];
  logic [`ICACHE_AGE_W-1:0] ref_age   [`ICACHE_WAYS][sets];

  icache_top UUT (
    .clk     (clk),
    .rst     (rst),
    .insaddr (insaddr),
    .req     (req),
    .ins     (ins),
    .ok      (ok),
    .sen     (sen),
    .addr    (addr),
    .data_ok (data_ok),
    .sdata   (sdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return a ^ 32'h5a5a0000;
  endfunction

  ////////////////////
  // Memory model

  initial
  begin
    int          beat;
    int          gap;
    logic        in_burst;
    logic [31:0] burst_start;
    logic [3:0]  wrap;
    void'($urandom(32'hc655));
    beat        = 0;
    gap         = 0;
    in_burst    = 1'b0;
    burst_start = '0;
    data_ok     = 1'b0;
    sdata       = '0;
    forever
    begin
      @(posedge clk);
      data_ok <= 1'b0;
      if (!sen)
      begin
        in_burst = 1'b0;
        beat     = 0;
      end
      else if (beat < `ICACHE_LINE_WORDS)
      begin
        if (!in_burst)
        begin
          in_burst    = 1'b1;
          burst_start = addr;
          gap         = $urandom % 4;
        end
        if (gap > 0)
          gap--;
        else
        begin
          // Wrap inside the line from the requested word
          wrap = burst_start[5:2] + 4'(beat);
          data_ok <= 1'b1;
          sdata   <= mem_word({burst_start[31:6], wrap, 2'b00});
          beat++;
          gap = $urandom % 4;
        end
      end
    end
  end

  ////////////////////
  // Reference model

  function automatic int pick_victim(input logic [`ICACHE_INDEX_W-1:0] idx);
    int v;
    v = -1;
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      if (!ref_valid[w][idx] && v < 0)
        v = w;
    end
    if (v < 0)
    begin
      v = 0;
      for (int w = 1; w < `ICACHE_WAYS; w++)
      begin
        if (ref_age[w][idx] > ref_age[v][idx])
          v = w;
      end
    end
    return v;
  endfunction

  task automatic build_table();
    icache_pkg::addr_fields_t f;
    int                       hit_w;
    logic [`ICACHE_AGE_W-1:0] hit_age;
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      for (int s = 0; s < sets; s++)
      begin
        ref_valid[w][s] = 1'b0;
        ref_tag[w][s]   = '0;
        ref_age[w][s]   = '0;
      end
    end
    for (int i = 0; i < n_entries; i++)
    begin
      stim_table[i].addr = stim_addr[i];
      f     = stim_addr[i][31:2];
      hit_w = -1;
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
        if (ref_valid[w][f.index] && ref_tag[w][f.index] == f.tag)
          hit_w = w;
      end
      stim_table[i].miss = (hit_w < 0);
      // A miss fills the victim, then the retried lookup hits it
      if (hit_w < 0)
      begin
        hit_w = pick_victim(f.index);
        ref_valid[hit_w][f.index] = 1'b1;
        ref_tag[hit_w][f.index]   = f.tag;
      end
      hit_age = ref_age[hit_w][f.index];
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
        if (ref_age[w][f.index] <= hit_age)
          ref_age[w][f.index] = ref_age[w][f.index] + 1'b1;
      end
      ref_age[hit_w][f.index] = '0;
    end
  endtask

  ////////////////////
  // Checks

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_burst(input icache_pkg::addr_fields_t got,
                             input icache_pkg::addr_fields_t exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("FAILED at %0t: %s tag %h index %h offset %h, expected %h %h %h",
               $time, what, got.tag, got.index, got.offset,
               exp.tag, exp.index, exp.offset);
    end
  endtask

  task automatic run_request(input int i, output logic timeout_hit);
    icache_pkg::addr_fields_t req_f;
    icache_pkg::addr_fields_t burst_f;
    logic [31:0]              got_ins;
    logic                     sen_seen;
    logic                     got_ok;
    int                       cycles;
    int                       strobes;
    req_f       = stim_table[i].addr[31:2];
    burst_f     = '0;
    got_ins     = '0;
    sen_seen    = 1'b0;
    got_ok      = 1'b0;
    cycles      = 0;
    strobes     = 0;
    timeout_hit = 1'b0;
    @(posedge clk);
    req     <= 1'b1;
    insaddr <= stim_table[i].addr;
    while (!got_ok && cycles < ok_timeout)
    begin
      @(negedge clk);
      cycles++;
      if (data_ok)
        strobes++;
      if (sen && !sen_seen)
      begin
        sen_seen = 1'b1;
        burst_f  = addr[31:2];
      end
      if (ok)
      begin
        got_ok  = 1'b1;
        got_ins = ins;
      end
    end
    @(posedge clk);
    req <= 1'b0;
    if (!got_ok)
    begin
      err_count++;
      timeout_hit = 1'b1;
      $display("Timeout: no ok for entry %0d after %0d cycles", i, cycles);
    end
    else
    begin
      check_flag(sen_seen, stim_table[i].miss, $sformatf("miss flag of entry %0d", i));
      check_flag(strobes == (stim_table[i].miss ? `ICACHE_LINE_WORDS : 0), 1'b1,
                 $sformatf("data_ok count of entry %0d", i));
      if (sen_seen)
        check_burst(burst_f, req_f, $sformatf("burst start of entry %0d", i));
      if (!stim_table[i].miss)
        check_flag(cycles == 2, 1'b1, $sformatf("hit latency of entry %0d", i));
      check_word(got_ins, mem_word({req_f, 2'b00}), $sformatf("ins of entry %0d", i));
    end
  endtask

  ////////////////////
  // Main sequence

  initial
  begin
    rst         = 1'b1;
    req         = 1'b0;
    insaddr     = '0;
    err_count   = 0;
    check_count = 0;
    timed_out   = 1'b0;
    build_table();
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Quiet outputs while idle
    repeat (3)
    begin
      @(negedge clk);
      check_flag(ok, 1'b0, "ok after reset");
      check_flag(sen, 1'b0, "sen after reset");
    end

    for (int i = 0; i < n_entries && !timed_out; i++)
      run_request(i, timed_out);

    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- way_store.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module way_store (
  input  logic                     clk,
  input  logic                     rst,
  input  icache_pkg::addr_fields_t req_fields,
  input  logic                     lookup,
  input  icache_pkg::fill_t        fill,
  input  icache_pkg::line_t        line,
  output logic                     hit,
  output icache_pkg::way_t         victim,
  output logic [31:0]              ins
);

  localparam int sets = 1 << `ICACHE_INDEX_W;

  logic [`ICACHE_TAG_W-1:0] tag_mem  [`ICACHE_WAYS][sets];
  icache_pkg::line_t        data_mem [`ICACHE_WAYS][sets];

  logic [`ICACHE_WAYS-1:0][sets-1:0]                     valid;
  logic [`ICACHE_WAYS-1:0][sets-1:0][`ICACHE_AGE_W-1:0] age;

  logic [`ICACHE_INDEX_W-1:0] idx;
  logic [`ICACHE_WAYS-1:0]    hit_vec;
  icache_pkg::way_t           hit_way;
  logic [`ICACHE_AGE_W-1:0]   hit_age;
  logic                       free_found;

  assign idx = req_fields.index;

  ////////////////////
  // Lookup

  always_comb
  begin
    hit_vec = '0;
    hit_way = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      hit_vec[w] = valid[w][idx] && (tag_mem[w][idx] == req_fields.tag);
      if (hit_vec[w])
        hit_way = icache_pkg::way_t'(w);
    end
  end

  assign hit     = |hit_vec;
  assign hit_age = age[hit_way][idx];
  assign ins     = data_mem[hit_way][idx][req_fields.offset];

  // First free way, else the oldest one
  always_comb
  begin
    free_found = 1'b0;
    victim     = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      if (!valid[w][idx] && !free_found)
      begin
        victim     = icache_pkg::way_t'(w);
        free_found = 1'b1;
      end
    end
    if (!free_found)
    begin
      for (int w = 1; w < `ICACHE_WAYS; w++)
      begin
        if (age[w][idx] > age[victim][idx])
          victim = icache_pkg::way_t'(w);
      end
    end
  end

  ////////////////////
  // State update

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid <= '0;
      age   <= '0;
    end
    else
    begin
      if (fill.we)
        valid[fill.way][fill.index] <= 1'b1;
      if (lookup && hit)
      begin
        // Ways no older than the hit way grow older
        for (int w = 0; w < `ICACHE_WAYS; w++)
        begin
          if (age[w][idx] <= hit_age)
            age[w][idx] <= age[w][idx] + 1'b1;
        end
        age[hit_way][idx] <= '0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill.we)
    begin
      tag_mem[fill.way][fill.index]  <= fill.tag;
      data_mem[fill.way][fill.index] <= line;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    lookup |-> $onehot0(hit_vec));

  // A freshly written line must hit on the following lookup
  assert property (@(posedge clk) disable iff (rst)
    fill.we |=> lookup && hit);

endmodule
